/* verilog/cluster_feature_pkg.sv */
package cluster_feature_pkg;

    // ========================================================================
    // Sizes
    // ========================================================================
    localparam int COORD_BITS       = 5;                        // 32 cells per axis
    localparam int LABEL_BITS       = 6;                        // 64 labels, 0 is unlabeled
    localparam int NUM_BANKS        = 4;
    localparam int BANK_SEL_BITS    = $clog2(NUM_BANKS);        // Low label bits pick the bank
    localparam int INDEX_BITS       = LABEL_BITS - BANK_SEL_BITS;
    localparam int BANK_DEPTH       = 1 << INDEX_BITS;
    localparam int SIZE_BITS        = 12;                       // Saturating voxel count
    localparam int MIN_CLUSTER_SIZE = 8;
    localparam int COUNT_BITS       = 7;

    // Bank command opcodes
    typedef enum logic [1:0] {
        OP_IDLE  = 2'd0,
        OP_ADD   = 2'd1,
        OP_CLEAR = 2'd2
    } bank_op_e;

    // ========================================================================
    // Stream and bank records
    // ========================================================================
    typedef struct packed {
        logic                  last;   // Final voxel of the frame
        logic [LABEL_BITS-1:0] label;
        logic [COORD_BITS-1:0] x;
        logic [COORD_BITS-1:0] y;
        logic [COORD_BITS-1:0] z;
    } voxel_t;

    typedef struct packed {
        bank_op_e              op;
        logic [INDEX_BITS-1:0] index;  // Upper label bits
        logic [COORD_BITS-1:0] x;
        logic [COORD_BITS-1:0] y;
        logic [COORD_BITS-1:0] z;
    } bank_cmd_t;

    // Size zero marks an empty entry
    typedef struct packed {
        logic [SIZE_BITS-1:0]  size;
        logic [COORD_BITS-1:0] min_x;
        logic [COORD_BITS-1:0] max_x;
        logic [COORD_BITS-1:0] min_y;
        logic [COORD_BITS-1:0] max_y;
        logic [COORD_BITS-1:0] min_z;
        logic [COORD_BITS-1:0] max_z;
    } cluster_stats_t;

    typedef struct packed {
        logic                  found;          // At least one cluster qualified
        logic [COUNT_BITS-1:0] cluster_count;
        logic [SIZE_BITS-1:0]  size;           // Largest qualifying cluster
        logic [COORD_BITS-1:0] centroid_x;
        logic [COORD_BITS-1:0] centroid_y;
        logic [COORD_BITS-1:0] centroid_z;
        logic [COORD_BITS-1:0] dim_x;
        logic [COORD_BITS-1:0] dim_y;
        logic [COORD_BITS-1:0] dim_z;
    } feature_t;

endpackage

/* verilog/voxel_dispatch.sv */
`timescale 1ns/1ps

module voxel_dispatch (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              voxel_valid,
    output logic                              voxel_ready,
    input  cluster_feature_pkg::voxel_t       voxel,
    input  logic                              result_taken,
    output cluster_feature_pkg::bank_cmd_t    bank_cmd [cluster_feature_pkg::NUM_BANKS],
    output logic                              scan_start
);

    typedef enum logic [1:0] {
        ACCUMULATE,
        WAIT_RESULT,
        CLEAR
    } dispatch_state_e;

    dispatch_state_e                           state;
    logic                                      accept;
    logic                                      last_cmd;   // Command of the last voxel is out
    cluster_feature_pkg::bank_op_e             op_q [cluster_feature_pkg::NUM_BANKS];
    logic [cluster_feature_pkg::INDEX_BITS-1:0] cmd_index;
    logic [cluster_feature_pkg::COORD_BITS-1:0] cmd_x;
    logic [cluster_feature_pkg::COORD_BITS-1:0] cmd_y;
    logic [cluster_feature_pkg::COORD_BITS-1:0] cmd_z;

    assign voxel_ready = (state != WAIT_RESULT);
    assign accept      = voxel_valid && voxel_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ACCUMULATE;
        end else begin
            case (state)
                ACCUMULATE, CLEAR: state <= (accept && voxel.last) ? WAIT_RESULT : ACCUMULATE;
                WAIT_RESULT:       if (result_taken) state <= CLEAR;
                default:           state <= ACCUMULATE;
            endcase
        end
    end

    // ========================================================================
    // Per-bank opcodes and frame sequencing
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int b = 0; b < cluster_feature_pkg::NUM_BANKS; b++) begin
                op_q[b] <= cluster_feature_pkg::OP_IDLE;
            end
            last_cmd   <= 1'b0;
            scan_start <= 1'b0;
        end else begin
            last_cmd   <= accept && voxel.last;
            scan_start <= last_cmd;                 // Bank has applied the last add by now
            for (int b = 0; b < cluster_feature_pkg::NUM_BANKS; b++) begin
                op_q[b] <= cluster_feature_pkg::OP_IDLE;
            end
            // Label 0 is unlabeled and never reaches a bank
            if (accept && voxel.label != '0) begin
                op_q[voxel.label[cluster_feature_pkg::BANK_SEL_BITS-1:0]] <=
                    cluster_feature_pkg::OP_ADD;
            end
            if (state == WAIT_RESULT && result_taken) begin
                for (int b = 0; b < cluster_feature_pkg::NUM_BANKS; b++) begin
                    op_q[b] <= cluster_feature_pkg::OP_CLEAR;
                end
            end
        end
    end

    // Shared payload, only the opcode differs per bank
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_index <= voxel.label[cluster_feature_pkg::LABEL_BITS-1:
                                     cluster_feature_pkg::BANK_SEL_BITS];
            cmd_x     <= voxel.x;
            cmd_y     <= voxel.y;
            cmd_z     <= voxel.z;
        end
    end

    always_comb begin
        for (int b = 0; b < cluster_feature_pkg::NUM_BANKS; b++) begin
            bank_cmd[b].op    = op_q[b];
            bank_cmd[b].index = cmd_index;
            bank_cmd[b].x     = cmd_x;
            bank_cmd[b].y     = cmd_y;
            bank_cmd[b].z     = cmd_z;
        end
    end

endmodule

/* verilog/cluster_bank.sv */
`timescale 1ns/1ps

module cluster_bank (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  cluster_feature_pkg::bank_cmd_t         cmd,
    input  logic [cluster_feature_pkg::INDEX_BITS-1:0] scan_index,
    output cluster_feature_pkg::cluster_stats_t    scan_entry
);

    logic [cluster_feature_pkg::BANK_DEPTH-1:0] entry_used;    // Cleared in one cycle
    cluster_feature_pkg::cluster_stats_t        entry_mem [cluster_feature_pkg::BANK_DEPTH];
    cluster_feature_pkg::cluster_stats_t        cur_entry;
    cluster_feature_pkg::cluster_stats_t        upd_entry;

    function automatic logic [cluster_feature_pkg::COORD_BITS-1:0] coord_min(
        input logic [cluster_feature_pkg::COORD_BITS-1:0] a,
        input logic [cluster_feature_pkg::COORD_BITS-1:0] b
    );
        return (a < b) ? a : b;
    endfunction

    function automatic logic [cluster_feature_pkg::COORD_BITS-1:0] coord_max(
        input logic [cluster_feature_pkg::COORD_BITS-1:0] a,
        input logic [cluster_feature_pkg::COORD_BITS-1:0] b
    );
        return (a > b) ? a : b;
    endfunction

    // ========================================================================
    // Read-modify-write of the addressed cluster
    // ========================================================================
    always_comb begin
        cur_entry = entry_mem[cmd.index];
        upd_entry = cur_entry;
        if (!entry_used[cmd.index]) begin
            // First voxel of this cluster
            upd_entry.size  = (cluster_feature_pkg::SIZE_BITS)'(1);
            upd_entry.min_x = cmd.x;
            upd_entry.max_x = cmd.x;
            upd_entry.min_y = cmd.y;
            upd_entry.max_y = cmd.y;
            upd_entry.min_z = cmd.z;
            upd_entry.max_z = cmd.z;
        end else begin
            if (cur_entry.size != '1) upd_entry.size = cur_entry.size + 1'b1;  // Saturate
            upd_entry.min_x = coord_min(cmd.x, cur_entry.min_x);
            upd_entry.max_x = coord_max(cmd.x, cur_entry.max_x);
            upd_entry.min_y = coord_min(cmd.y, cur_entry.min_y);
            upd_entry.max_y = coord_max(cmd.y, cur_entry.max_y);
            upd_entry.min_z = coord_min(cmd.z, cur_entry.min_z);
            upd_entry.max_z = coord_max(cmd.z, cur_entry.max_z);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_used <= '0;
        end else begin
            case (cmd.op)
                cluster_feature_pkg::OP_ADD:   entry_used[cmd.index] <= 1'b1;
                cluster_feature_pkg::OP_CLEAR: entry_used <= '0;
                default:                       entry_used <= entry_used;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.op == cluster_feature_pkg::OP_ADD) begin
            entry_mem[cmd.index] <= upd_entry;
        end
    end

    // Scan port, unused entries read back as empty
    assign scan_entry = entry_used[scan_index] ? entry_mem[scan_index] : '0;

endmodule

/* verilog/cluster_select.sv */
`timescale 1ns/1ps

module cluster_select (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   scan_start,
    output logic [cluster_feature_pkg::INDEX_BITS-1:0] scan_index,
    input  cluster_feature_pkg::cluster_stats_t    scan_entry [cluster_feature_pkg::NUM_BANKS],
    output logic                                   result_valid,
    output cluster_feature_pkg::feature_t          result,
    output cluster_feature_pkg::cluster_stats_t    best
);

    logic                                       scanning;
    logic [cluster_feature_pkg::COUNT_BITS-1:0] count_q;
    logic [cluster_feature_pkg::COUNT_BITS-1:0] count_next;
    cluster_feature_pkg::cluster_stats_t        best_q;
    cluster_feature_pkg::cluster_stats_t        best_next;

    // ========================================================================
    // Compare one row of all banks against the running best
    // ========================================================================
    // Ascending bank order within a row keeps labels ascending overall,
    // so a strict compare leaves ties with the lower label
    always_comb begin
        count_next = count_q;
        best_next  = best_q;
        for (int b = 0; b < cluster_feature_pkg::NUM_BANKS; b++) begin
            if (scan_entry[b].size >= cluster_feature_pkg::MIN_CLUSTER_SIZE) begin
                count_next = count_next + 1'b1;
                if (scan_entry[b].size > best_next.size) begin
                    best_next = scan_entry[b];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scanning     <= 1'b0;
            scan_index   <= '0;
            count_q      <= '0;
            best_q       <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            if (scan_start) begin
                // Fresh frame
                scanning   <= 1'b1;
                scan_index <= '0;
                count_q    <= '0;
                best_q     <= '0;
            end else if (scanning) begin
                count_q    <= count_next;
                best_q     <= best_next;
                scan_index <= scan_index + 1'b1;        // Wraps back to 0 after the last row
                if (scan_index == cluster_feature_pkg::BANK_DEPTH - 1) begin
                    scanning     <= 1'b0;
                    result_valid <= 1'b1;
                end
            end
        end
    end

    // ========================================================================
    // Result toward the encoder
    // ========================================================================
    assign best = best_q;

    always_comb begin
        result               = '0;                      // Geometry filled in downstream
        result.found         = (count_q != '0);
        result.cluster_count = count_q;
        result.size          = best_q.size;
    end

endmodule

/* verilog/feature_encoder.sv */
`timescale 1ns/1ps

module feature_encoder (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                result_valid,
    input  cluster_feature_pkg::feature_t       result,
    input  cluster_feature_pkg::cluster_stats_t best,
    output logic                                feature_valid,
    input  logic                                feature_ready,
    output cluster_feature_pkg::feature_t       feature,
    output logic                                result_taken
);

    cluster_feature_pkg::feature_t rec_next;

    // Floor of (lo + hi) / 2 without overflow
    function automatic logic [cluster_feature_pkg::COORD_BITS-1:0] midpoint(
        input logic [cluster_feature_pkg::COORD_BITS-1:0] lo,
        input logic [cluster_feature_pkg::COORD_BITS-1:0] hi
    );
        logic [cluster_feature_pkg::COORD_BITS:0] sum;
        sum = {1'b0, lo} + {1'b0, hi};
        return sum[cluster_feature_pkg::COORD_BITS:1];
    endfunction

    always_comb begin
        rec_next = result;
        if (result.found) begin
            rec_next.centroid_x = midpoint(best.min_x, best.max_x);
            rec_next.centroid_y = midpoint(best.min_y, best.max_y);
            rec_next.centroid_z = midpoint(best.min_z, best.max_z);
            rec_next.dim_x      = best.max_x - best.min_x;     // min never exceeds max
            rec_next.dim_y      = best.max_y - best.min_y;
            rec_next.dim_z      = best.max_z - best.min_z;
        end
    end

    assign result_taken = feature_valid && feature_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            feature_valid <= 1'b0;
        end else if (result_valid) begin
            feature_valid <= 1'b1;
        end else if (result_taken) begin
            feature_valid <= 1'b0;                         // Record handed off
        end
    end

    // Record held stable while waiting on feature_ready
    always_ff @(posedge clk) begin
        if (result_valid) feature <= rec_next;
    end

endmodule

/* verilog/cluster_feature_top.sv */
`timescale 1ns/1ps

module cluster_feature_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          voxel_valid,
    output logic                          voxel_ready,
    input  cluster_feature_pkg::voxel_t   voxel,
    output logic                          feature_valid,
    input  logic                          feature_ready,
    output cluster_feature_pkg::feature_t feature
);

    cluster_feature_pkg::bank_cmd_t             bank_cmd   [cluster_feature_pkg::NUM_BANKS];
    cluster_feature_pkg::cluster_stats_t        scan_entry [cluster_feature_pkg::NUM_BANKS];
    logic [cluster_feature_pkg::INDEX_BITS-1:0] scan_index;
    logic                                       scan_start;
    logic                                       result_valid;
    logic                                       result_taken;
    cluster_feature_pkg::feature_t              result;
    cluster_feature_pkg::cluster_stats_t        best;

    // ========================================================================
    // Accumulation
    // ========================================================================
    voxel_dispatch dispatch_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .voxel_valid  (voxel_valid),
        .voxel_ready  (voxel_ready),
        .voxel        (voxel),
        .result_taken (result_taken),
        .bank_cmd     (bank_cmd),
        .scan_start   (scan_start)
    );

    // Label bank = low label bits
    for (genvar g = 0; g < cluster_feature_pkg::NUM_BANKS; g++) begin : g_bank
        cluster_bank bank_i (
            .clk        (clk),
            .rst_n      (rst_n),
            .cmd        (bank_cmd[g]),
            .scan_index (scan_index),
            .scan_entry (scan_entry[g])
        );
    end

    // ========================================================================
    // Scan and output record
    // ========================================================================
    cluster_select select_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .scan_start   (scan_start),
        .scan_index   (scan_index),
        .scan_entry   (scan_entry),
        .result_valid (result_valid),
        .result       (result),
        .best         (best)
    );

    feature_encoder encoder_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .result_valid  (result_valid),
        .result        (result),
        .best          (best),
        .feature_valid (feature_valid),
        .feature_ready (feature_ready),
        .feature       (feature),
        .result_taken  (result_taken)
    );

endmodule

/* dv/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD  = 4;        // 8 ns clock
    localparam int RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;                      // Released on a rising edge
    end

endmodule

/* dv/cluster_feature_tb.sv */
`timescale 1ns/1ps

module cluster_feature_tb;

    localparam int RESET_CYCLES = 16;
    localparam int FRAME_VOXELS = 10 + 71 + 19 + 9 + 11 + 150;     // Sum over all test frames
    localparam int NUM_FRAMES   = 6;
    localparam int FRAME_GAP    = cluster_feature_pkg::BANK_DEPTH + 8;  // Scan plus handshakes
    localparam int MAX_STALL    = 20;
    localparam int CYCLE_LIMIT  =
        2 * (RESET_CYCLES + FRAME_VOXELS + NUM_FRAMES * FRAME_GAP + MAX_STALL);

    logic                          clk;
    logic                          rst_n;
    logic                          voxel_valid;
    logic                          voxel_ready;
    cluster_feature_pkg::voxel_t   voxel;
    logic                          feature_valid;
    logic                          feature_ready;
    cluster_feature_pkg::feature_t feature;

    cluster_feature_pkg::voxel_t   frame_q [$];     // Voxels of the frame being sent
    int                            seed        = 6115;
    int                            cycle_count = 0;

    tb_clock_gen clock_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    cluster_feature_top dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .voxel_valid   (voxel_valid),
        .voxel_ready   (voxel_ready),
        .voxel         (voxel),
        .feature_valid (feature_valid),
        .feature_ready (feature_ready),
        .feature       (feature)
    );

    // ========================================================================
    // Error handling and compare tasks
    // ========================================================================
    task automatic abort_run();
        $display("Checks failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [15:0] expected,
                                   input logic [15:0] actual);
        $display("FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
        abort_run();
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            report_mismatch(name, 16'(expected), 16'(actual));
        end
    endtask

    task automatic check_feature(input string name,
                                 input cluster_feature_pkg::feature_t expected,
                                 input cluster_feature_pkg::feature_t actual);
        if (actual.found !== expected.found)
            report_mismatch({name, ".found"}, 16'(expected.found), 16'(actual.found));
        else if (actual.cluster_count !== expected.cluster_count)
            report_mismatch({name, ".cluster_count"}, 16'(expected.cluster_count),
                            16'(actual.cluster_count));
        else if (actual.size !== expected.size)
            report_mismatch({name, ".size"}, 16'(expected.size), 16'(actual.size));
        else if (actual.centroid_x !== expected.centroid_x)
            report_mismatch({name, ".centroid_x"}, 16'(expected.centroid_x),
                            16'(actual.centroid_x));
        else if (actual.centroid_y !== expected.centroid_y)
            report_mismatch({name, ".centroid_y"}, 16'(expected.centroid_y),
                            16'(actual.centroid_y));
        else if (actual.centroid_z !== expected.centroid_z)
            report_mismatch({name, ".centroid_z"}, 16'(expected.centroid_z),
                            16'(actual.centroid_z));
        else if (actual.dim_x !== expected.dim_x)
            report_mismatch({name, ".dim_x"}, 16'(expected.dim_x), 16'(actual.dim_x));
        else if (actual.dim_y !== expected.dim_y)
            report_mismatch({name, ".dim_y"}, 16'(expected.dim_y), 16'(actual.dim_y));
        else if (actual.dim_z !== expected.dim_z)
            report_mismatch({name, ".dim_z"}, 16'(expected.dim_z), 16'(actual.dim_z));
    endtask

    // ========================================================================
    // Reference model
    // ========================================================================
    function automatic cluster_feature_pkg::feature_t model_frame();
        cluster_feature_pkg::cluster_stats_t   stats [1 << cluster_feature_pkg::LABEL_BITS];
        cluster_feature_pkg::cluster_stats_t   s;
        cluster_feature_pkg::feature_t         exp_rec;
        cluster_feature_pkg::voxel_t           v;
        logic [cluster_feature_pkg::SIZE_BITS-1:0]  best_size;
        logic [cluster_feature_pkg::COUNT_BITS-1:0] count;
        int                                    best_label;
        foreach (stats[l]) stats[l] = '0;
        foreach (frame_q[i]) begin
            v = frame_q[i];
            s = stats[v.label];
            if (s.size == '0) begin                 // New cluster
                s.min_x = v.x;
                s.max_x = v.x;
                s.min_y = v.y;
                s.max_y = v.y;
                s.min_z = v.z;
                s.max_z = v.z;
            end else begin
                if (v.x < s.min_x) s.min_x = v.x;
                if (v.x > s.max_x) s.max_x = v.x;
                if (v.y < s.min_y) s.min_y = v.y;
                if (v.y > s.max_y) s.max_y = v.y;
                if (v.z < s.min_z) s.min_z = v.z;
                if (v.z > s.max_z) s.max_z = v.z;
            end
            if (s.size != '1) s.size = s.size + 1'b1;
            if (v.label != '0) stats[v.label] = s;  // Unlabeled voxels are dropped
        end
        count      = '0;
        best_size  = '0;
        best_label = 0;
        // Only a strictly larger size replaces the best in ascending label order
        for (int l = 1; l < (1 << cluster_feature_pkg::LABEL_BITS); l++) begin
            if (stats[l].size >= cluster_feature_pkg::MIN_CLUSTER_SIZE) begin
                count = count + 1'b1;
                if (stats[l].size > best_size) begin
                    best_size  = stats[l].size;
                    best_label = l;
                end
            end
        end
        exp_rec               = '0;
        exp_rec.cluster_count = count;
        if (count != '0) begin
            s                  = stats[best_label];
            exp_rec.found      = 1'b1;
            exp_rec.size       = s.size;
            exp_rec.centroid_x = (cluster_feature_pkg::COORD_BITS)'(
                (int'(s.min_x) + int'(s.max_x)) / 2);
            exp_rec.centroid_y = (cluster_feature_pkg::COORD_BITS)'(
                (int'(s.min_y) + int'(s.max_y)) / 2);
            exp_rec.centroid_z = (cluster_feature_pkg::COORD_BITS)'(
                (int'(s.min_z) + int'(s.max_z)) / 2);
            exp_rec.dim_x      = s.max_x - s.min_x;
            exp_rec.dim_y      = s.max_y - s.min_y;
            exp_rec.dim_z      = s.max_z - s.min_z;
        end
        return exp_rec;
    endfunction

    // ========================================================================
    // Stimulus
    // ========================================================================
    task automatic add_cluster(input int label, input int count, input int bx,
                               input int by, input int bz);
        cluster_feature_pkg::voxel_t v;
        for (int i = 0; i < count; i++) begin
            v.last  = 1'b0;
            v.label = (cluster_feature_pkg::LABEL_BITS)'(label);
            v.x     = (cluster_feature_pkg::COORD_BITS)'(bx + i % 5);
            v.y     = (cluster_feature_pkg::COORD_BITS)'(by + i % 3);
            v.z     = (cluster_feature_pkg::COORD_BITS)'(bz + i / 4);
            frame_q.push_back(v);
        end
    endtask

    // Starts on a rising edge and returns on the edge of the last transfer
    task automatic send_frame();
        frame_q[frame_q.size() - 1].last = 1'b1;
        foreach (frame_q[i]) begin
            voxel_valid <= 1'b1;
            voxel       <= frame_q[i];
            @(posedge clk);
            while (!voxel_ready) @(posedge clk);
        end
        voxel_valid <= 1'b0;
    endtask

    task automatic receive_feature(input int stall, output cluster_feature_pkg::feature_t got);
        cluster_feature_pkg::feature_t held;
        feature_ready <= 1'b0;
        @(posedge clk);
        while (!feature_valid) begin
            check_bit("voxel_ready", 1'b0, voxel_ready);    // Frame closed until handoff
            @(posedge clk);
        end
        held = feature;
        repeat (stall) begin
            @(posedge clk);
            check_bit("feature_valid", 1'b1, feature_valid);
            check_bit("voxel_ready", 1'b0, voxel_ready);
            check_feature("feature", held, feature);
        end
        feature_ready <= 1'b1;
        @(posedge clk);                                     // Transfer edge
        check_bit("feature_valid", 1'b1, feature_valid);
        feature_ready <= 1'b0;
        got = held;
        @(posedge clk);
        check_bit("feature_valid", 1'b0, feature_valid);
        check_bit("voxel_ready", 1'b1, voxel_ready);
    endtask

    // ========================================================================
    // Directed tests
    // ========================================================================
    task automatic reset_state_test();
        check_bit("feature_valid", 1'b0, feature_valid);
        check_bit("voxel_ready", 1'b1, voxel_ready);
    endtask

    task automatic single_cluster_test();
        cluster_feature_pkg::feature_t got;
        cluster_feature_pkg::feature_t exp_rec;
        frame_q.delete();
        add_cluster(5, 10, 3, 20, 10);          // x 3..7, y 20..22, z 10..12
        send_frame();
        receive_feature(0, got);
        exp_rec               = '0;
        exp_rec.found         = 1'b1;
        exp_rec.cluster_count = 7'd1;
        exp_rec.size          = 12'd10;
        exp_rec.centroid_x    = 5'd5;
        exp_rec.centroid_y    = 5'd21;
        exp_rec.centroid_z    = 5'd11;
        exp_rec.dim_x         = 5'd4;
        exp_rec.dim_y         = 5'd2;
        exp_rec.dim_z         = 5'd2;
        check_feature("feature", exp_rec, got);
    endtask

    task automatic mixed_bank_test();
        cluster_feature_pkg::feature_t got;
        frame_q.delete();
        add_cluster(1, 9, 2, 2, 2);
        add_cluster(0, 14, 26, 26, 26);         // Unlabeled and larger than any real cluster
        add_cluster(2, 12, 10, 4, 6);           // Ties with label 3 and wins as the lower label
        add_cluster(3, 12, 20, 14, 1);
        add_cluster(0, 2, 0, 0, 0);
        add_cluster(4, 7, 5, 25, 15);           // One short of qualifying
        add_cluster(8, 8, 25, 10, 20);          // Exactly the minimum
        add_cluster(63, 5, 1, 1, 28);
        add_cluster(0, 2, 9, 9, 9);             // Last voxel unlabeled
        send_frame();
        receive_feature(0, got);
        check_feature("feature", model_frame(), got);
    endtask

    task automatic small_cluster_test();
        cluster_feature_pkg::feature_t got;
        frame_q.delete();
        add_cluster(6, 5, 12, 12, 12);
        add_cluster(7, 7, 0, 18, 3);
        add_cluster(9, 3, 27, 2, 22);
        add_cluster(0, 4, 14, 6, 8);
        send_frame();
        receive_feature(0, got);
        check_feature("feature", model_frame(), got);
    endtask

    task automatic back_pressure_test();
        cluster_feature_pkg::feature_t got;
        int                            stall;
        stall = 1 + {$random(seed)} % MAX_STALL;
        frame_q.delete();
        add_cluster(10, 9, 4, 4, 4);
        send_frame();
        receive_feature(stall, got);
        check_feature("feature", model_frame(), got);
        // Leftover counts of the same label would show in size
        frame_q.delete();
        add_cluster(10, 8, 16, 16, 16);
        add_cluster(11, 3, 0, 0, 0);
        send_frame();
        receive_feature(0, got);
        check_feature("feature", model_frame(), got);
    endtask

    task automatic random_frame_test();
        cluster_feature_pkg::feature_t got;
        cluster_feature_pkg::voxel_t   v;
        frame_q.delete();
        for (int i = 0; i < 150; i++) begin
            v.last  = 1'b0;
            v.label = (cluster_feature_pkg::LABEL_BITS)'({$random(seed)} % 20);  // Near threshold
            v.x     = (cluster_feature_pkg::COORD_BITS)'({$random(seed)} % 32);
            v.y     = (cluster_feature_pkg::COORD_BITS)'({$random(seed)} % 32);
            v.z     = (cluster_feature_pkg::COORD_BITS)'({$random(seed)} % 32);
            frame_q.push_back(v);
        end
        send_frame();
        receive_feature(0, got);
        check_feature("feature", model_frame(), got);
    endtask

    // Hung handshake guard
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            abort_run();
        end
    end

    initial begin
        voxel_valid   = 1'b0;
        voxel         = '0;
        feature_ready = 1'b0;
        wait (rst_n === 1'b1);
        @(posedge clk);
        reset_state_test();
        single_cluster_test();
        mixed_bank_test();
        small_cluster_test();
        back_pressure_test();
        random_frame_test();
        $display("All checks passed");
        $finish;
    end

endmodule

/* src.f */
verilog/cluster_feature_pkg.sv
verilog/voxel_dispatch.sv
verilog/cluster_bank.sv
verilog/cluster_select.sv
verilog/feature_encoder.sv
verilog/cluster_feature_top.sv
dv/tb_clock_gen.sv
dv/cluster_feature_tb.sv

/* Bender.yml */
package:
  name: cluster_feature

sources:
  - verilog/cluster_feature_pkg.sv
  - verilog/voxel_dispatch.sv
  - verilog/cluster_bank.sv
  - verilog/cluster_select.sv
  - verilog/feature_encoder.sv
  - verilog/cluster_feature_top.sv
  - target: test
    files:
      - dv/tb_clock_gen.sv
      - dv/cluster_feature_tb.sv
